/* hw/ufc_link_pkg.sv */
`default_nettype none

// framing constants of the Aurora user flow control channel
package ufc_link_pkg;

   // width of the UFC message size field
   localparam int UFC_MS_WIDTH = 8;

   // size code is the byte count minus one
   // 7 means eight bytes, so one 64 bit word per message
   localparam logic [UFC_MS_WIDTH-1:0] UFC_MS_ONE_WORD = 8'd7;

endpackage

`default_nettype wire

/* hw/bridge_reg_pkg.sv */
`default_nettype none

package bridge_reg_pkg;

   localparam int REG_ADDR_WIDTH = 2;
   typedef logic [REG_ADDR_WIDTH-1:0] reg_addr_t;

   localparam int REG_WORD_WIDTH = 32;
   typedef logic [REG_WORD_WIDTH-1:0] reg_word_t;

   // register map
   localparam reg_addr_t REG_STATUS        = 2'd0;
   localparam reg_addr_t REG_TX_MSG_COUNT  = 2'd1;
   localparam reg_addr_t REG_RX_WORD_COUNT = 2'd2;
   localparam reg_addr_t REG_CONTROL       = 2'd3;

   // status bits
   localparam int STATUS_ERR_BIT      = 0;
   localparam int STATUS_RX_EMPTY_BIT = 1;
   localparam int STATUS_TX_EMPTY_BIT = 2;

   localparam int CTRL_CLEAR_BIT = 0; // write 1 clears both counters

endpackage

`default_nettype wire

/* hw/ufc_bridge_if.sv */
`timescale 1ns/1ps
`default_nettype none

// one side of a FIFO, as seen by whoever pushes, pops or stores
interface fifo_port_if #(
   parameter int FIFO_DATA_WIDTH = 32
);
   logic [FIFO_DATA_WIDTH-1:0] wdata;
   logic                       wren;
   logic                       full;
   logic [FIFO_DATA_WIDTH-1:0] q;     // head word, valid while empty is low
   logic                       rden;  // pops the head word at the edge
   logic                       empty;

   modport producer (
      output wdata, wren,
      input  full
   );

   modport consumer (
      input  q, empty,
      output rden
   );

   modport store (
      input  wdata, wren, rden,
      output full, q, empty
   );
endinterface

// transmit half of the UFC channel
interface ufc_tx_if #(
   parameter int AURORA_DATA_WIDTH = 64
);
   logic                                 req;    // one cycle pulse
   logic [ufc_link_pkg::UFC_MS_WIDTH-1:0] ms;
   logic [AURORA_DATA_WIDTH-1:0]         tdata;
   logic                                 tvalid; // held until tready
   logic                                 tready;

   modport source (output req, ms, tdata, tvalid, input tready);
   modport sink   (input req, ms, tdata, tvalid, output tready);
endinterface

`default_nettype wire

/* hw/sync_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

// single clock FIFO, head word shows on q without a read
module sync_fifo #(
   parameter int FIFO_DATA_WIDTH = 32,
   parameter int FIFO_DEPTH_LOG2 = 4
) (
   input  wire           AURORA_USER_CLK,
   input  wire           RESET,
   fifo_port_if.store    port
);

   localparam int DEPTH = 1 << FIFO_DEPTH_LOG2;

   logic [FIFO_DATA_WIDTH-1:0] mem [DEPTH];

   logic [FIFO_DEPTH_LOG2-1:0] wr_ptr;
   logic [FIFO_DEPTH_LOG2-1:0] rd_ptr;
   logic [FIFO_DEPTH_LOG2:0]   count;   // one extra bit to tell full from empty

   logic do_write;
   logic do_read;

   // a write into a full FIFO is lost, a read of an empty one does nothing
   assign do_write = port.wren && !port.full;
   assign do_read  = port.rden && !port.empty;

   assign port.full  = (count == DEPTH[FIFO_DEPTH_LOG2:0]);
   assign port.empty = (count == '0);
   assign port.q     = mem[rd_ptr];

   always_ff @(posedge AURORA_USER_CLK) begin
      if (do_write) begin
         mem[wr_ptr] <= port.wdata;
      end
   end

   always_ff @(posedge AURORA_USER_CLK or posedge RESET) begin
      if (RESET) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_write) begin
            wr_ptr <= wr_ptr + 1'b1; // wraps with the power of two depth
         end
         if (do_read) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({do_write, do_read})
            2'b10: begin
               count <= count + 1'b1;
            end
            2'b01: begin
               count <= count - 1'b1;
            end
            default: begin
               count <= count; // push and pop together leave it as is
            end
         endcase
      end
   end

endmodule

`default_nettype wire

/* hw/fifo_over_ufc.sv */
`timescale 1ns/1ps
`default_nettype none

module fifo_over_ufc #(
   parameter int FIFO_DATA_WIDTH   = 32,
   parameter int AURORA_DATA_WIDTH = 64
) (
   input  wire                         AURORA_USER_CLK,
   input  wire                         RESET,
   ufc_tx_if.source                    ufc_tx,
   input  wire [AURORA_DATA_WIDTH-1:0] rx_tdata,
   input  wire                         rx_tvalid,
   fifo_port_if.consumer               tx_fifo,
   fifo_port_if.producer               rx_fifo,
   output logic                        err
);

   localparam logic [1:0] IDLE       = 2'd0;
   localparam logic [1:0] REQUEST    = 2'd1;
   localparam logic [1:0] WAIT_READY = 2'd2;
   localparam logic [1:0] RELEASE    = 2'd3;

   logic [1:0] state;

   // every message carries exactly one word
   assign ufc_tx.ms = ufc_link_pkg::UFC_MS_ONE_WORD;

   // head word stays put until the pop, so tdata is stable under tvalid
   assign ufc_tx.tdata = {{(AURORA_DATA_WIDTH-FIFO_DATA_WIDTH){1'b0}}, tx_fifo.q};

   // transmit side, one FIFO word per UFC message
   always_ff @(posedge AURORA_USER_CLK or posedge RESET) begin
      if (RESET) begin
         state         <= IDLE;
         ufc_tx.req    <= 1'b0;
         ufc_tx.tvalid <= 1'b0;
         tx_fifo.rden  <= 1'b0;
      end else begin
         ufc_tx.req    <= 1'b0; // strobes default low
         ufc_tx.tvalid <= 1'b0;
         tx_fifo.rden  <= 1'b0;
         case (state)
            IDLE: begin
               if (!tx_fifo.empty) begin
                  ufc_tx.req <= 1'b1;
                  state      <= REQUEST;
               end
            end
            REQUEST: begin
               ufc_tx.tvalid <= 1'b1; // data follows the request by one cycle
               state         <= WAIT_READY;
            end
            WAIT_READY: begin
               if (ufc_tx.tready) begin
                  tx_fifo.rden <= 1'b1; // word accepted, drop it from the FIFO
                  state        <= RELEASE;
               end else begin
                  ufc_tx.tvalid <= 1'b1;
               end
            end
            RELEASE: begin
               // empty is not up to date until the pop has landed
               state <= IDLE;
            end
            default: begin
               state <= IDLE;
            end
         endcase
      end
   end

   // receive side has no back-pressure
   assign rx_fifo.wdata = rx_tdata[FIFO_DATA_WIDTH-1:0];
   assign rx_fifo.wren  = rx_tvalid;

   // overflow flag, only RESET clears it
   always_ff @(posedge AURORA_USER_CLK or posedge RESET) begin
      if (RESET) begin
         err <= 1'b0;
      end else if (rx_fifo.full) begin
         err <= 1'b1;
      end
   end

endmodule

`default_nettype wire

/* hw/ufc_bridge_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module ufc_bridge_regs (
   input  wire                       AURORA_USER_CLK,
   input  wire                       RESET,
   input  wire                       reg_wr,
   input  wire                       reg_rd,
   input  bridge_reg_pkg::reg_addr_t reg_addr,
   input  bridge_reg_pkg::reg_word_t reg_wdata,
   output bridge_reg_pkg::reg_word_t reg_rdata,
   input  wire                       err,
   input  wire                       tx_msg_done,     // tx FIFO pop, one per message
   input  wire                       rx_word_written, // rx FIFO write strobe
   input  wire                       rx_empty,
   input  wire                       tx_empty
);

   bridge_reg_pkg::reg_word_t tx_msg_count;
   bridge_reg_pkg::reg_word_t rx_word_count;
   bridge_reg_pkg::reg_word_t status;
   bridge_reg_pkg::reg_word_t rd_mux;

   logic clear_counts;

   assign clear_counts = reg_wr && (reg_addr == bridge_reg_pkg::REG_CONTROL)
                         && reg_wdata[bridge_reg_pkg::CTRL_CLEAR_BIT];

   // counters saturate at all ones, clear wins over a count
   always_ff @(posedge AURORA_USER_CLK or posedge RESET) begin
      if (RESET) begin
         tx_msg_count  <= '0;
         rx_word_count <= '0;
      end else if (clear_counts) begin
         tx_msg_count  <= '0;
         rx_word_count <= '0;
      end else begin
         if (tx_msg_done && (tx_msg_count != '1)) begin
            tx_msg_count <= tx_msg_count + 1'b1;
         end
         if (rx_word_written && (rx_word_count != '1)) begin
            rx_word_count <= rx_word_count + 1'b1;
         end
      end
   end

   always_comb begin
      status = '0;
      status[bridge_reg_pkg::STATUS_ERR_BIT]      = err;
      status[bridge_reg_pkg::STATUS_RX_EMPTY_BIT] = rx_empty;
      status[bridge_reg_pkg::STATUS_TX_EMPTY_BIT] = tx_empty;
   end

   always_comb begin
      case (reg_addr)
         bridge_reg_pkg::REG_STATUS: begin
            rd_mux = status;
         end
         bridge_reg_pkg::REG_TX_MSG_COUNT: begin
            rd_mux = tx_msg_count;
         end
         bridge_reg_pkg::REG_RX_WORD_COUNT: begin
            rd_mux = rx_word_count;
         end
         default: begin
            rd_mux = '0; // control reads back as zero
         end
      endcase
   end

   // read data lands one cycle after reg_rd and holds
   always_ff @(posedge AURORA_USER_CLK or posedge RESET) begin
      if (RESET) begin
         reg_rdata <= '0;
      end else if (reg_rd) begin
         reg_rdata <= rd_mux;
      end
   end

endmodule

`default_nettype wire

/* hw/ufc_bridge_top.sv */
`timescale 1ns/1ps
`default_nettype none

module ufc_bridge_top #(
   parameter int FIFO_DATA_WIDTH   = 32,
   parameter int AURORA_DATA_WIDTH = 64,
   parameter int FIFO_DEPTH_LOG2   = 4
) (
   input  wire                                   AURORA_USER_CLK,
   input  wire                                   RESET,
   // host transmit side
   input  wire  [FIFO_DATA_WIDTH-1:0]            host_tx_data,
   input  wire                                   host_tx_wr,
   output logic                                  host_tx_full,
   // host receive side
   output logic [FIFO_DATA_WIDTH-1:0]            host_rx_data,
   input  wire                                   host_rx_rd,
   output logic                                  host_rx_empty,
   // UFC transmit
   output logic                                  aurora_tx_req,
   output logic [ufc_link_pkg::UFC_MS_WIDTH-1:0] aurora_tx_ms,
   input  wire                                   aurora_tx_tready,
   output logic [AURORA_DATA_WIDTH-1:0]          aurora_tx_tdata,
   output logic                                  aurora_tx_tvalid,
   // link receive
   input  wire  [AURORA_DATA_WIDTH-1:0]          aurora_rx_tdata,
   input  wire                                   aurora_rx_tvalid,
   // register access
   input  wire                                   reg_wr,
   input  wire                                   reg_rd,
   input  bridge_reg_pkg::reg_addr_t             reg_addr,
   input  bridge_reg_pkg::reg_word_t             reg_wdata,
   output bridge_reg_pkg::reg_word_t             reg_rdata
);

   fifo_port_if #(.FIFO_DATA_WIDTH(FIFO_DATA_WIDTH)) tx_fifo_port ();
   fifo_port_if #(.FIFO_DATA_WIDTH(FIFO_DATA_WIDTH)) rx_fifo_port ();
   ufc_tx_if #(.AURORA_DATA_WIDTH(AURORA_DATA_WIDTH)) ufc_tx ();

   logic err;

   // host side of both FIFOs
   assign tx_fifo_port.wdata = host_tx_data;
   assign tx_fifo_port.wren  = host_tx_wr;
   assign host_tx_full       = tx_fifo_port.full;
   assign host_rx_data       = rx_fifo_port.q;
   assign rx_fifo_port.rden  = host_rx_rd;
   assign host_rx_empty      = rx_fifo_port.empty;

   // UFC transmit out to plain ports
   assign aurora_tx_req    = ufc_tx.req;
   assign aurora_tx_ms     = ufc_tx.ms;
   assign aurora_tx_tdata  = ufc_tx.tdata;
   assign aurora_tx_tvalid = ufc_tx.tvalid;
   assign ufc_tx.tready    = aurora_tx_tready;

   sync_fifo #(
      .FIFO_DATA_WIDTH (FIFO_DATA_WIDTH),
      .FIFO_DEPTH_LOG2 (FIFO_DEPTH_LOG2)
   ) tx_fifo (
      .AURORA_USER_CLK (AURORA_USER_CLK),
      .RESET           (RESET),
      .port            (tx_fifo_port)
   );

   sync_fifo #(
      .FIFO_DATA_WIDTH (FIFO_DATA_WIDTH),
      .FIFO_DEPTH_LOG2 (FIFO_DEPTH_LOG2)
   ) rx_fifo (
      .AURORA_USER_CLK (AURORA_USER_CLK),
      .RESET           (RESET),
      .port            (rx_fifo_port)
   );

   fifo_over_ufc #(
      .FIFO_DATA_WIDTH   (FIFO_DATA_WIDTH),
      .AURORA_DATA_WIDTH (AURORA_DATA_WIDTH)
   ) bridge (
      .AURORA_USER_CLK (AURORA_USER_CLK),
      .RESET           (RESET),
      .ufc_tx          (ufc_tx),
      .rx_tdata        (aurora_rx_tdata),
      .rx_tvalid       (aurora_rx_tvalid),
      .tx_fifo         (tx_fifo_port),
      .rx_fifo         (rx_fifo_port),
      .err             (err)
   );

   ufc_bridge_regs regs (
      .AURORA_USER_CLK (AURORA_USER_CLK),
      .RESET           (RESET),
      .reg_wr          (reg_wr),
      .reg_rd          (reg_rd),
      .reg_addr        (reg_addr),
      .reg_wdata       (reg_wdata),
      .reg_rdata       (reg_rdata),
      .err             (err),
      .tx_msg_done     (tx_fifo_port.rden),  // one pop per accepted message
      .rx_word_written (rx_fifo_port.wren),
      .rx_empty        (rx_fifo_port.empty),
      .tx_empty        (tx_fifo_port.empty)
   );

endmodule

`default_nettype wire

/* sim/tb_ufc_bridge.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_ufc_bridge;

   localparam int TIMEOUT_CYCLES = 500;

   logic        AURORA_USER_CLK = 1'b0;
   logic        RESET;
   logic [31:0] host_tx_data;
   logic        host_tx_wr;
   logic        host_tx_full;
   logic [31:0] host_rx_data;
   logic        host_rx_rd;
   logic        host_rx_empty;
   logic        aurora_tx_req;
   logic [7:0]  aurora_tx_ms;
   logic        aurora_tx_tready;
   logic [63:0] aurora_tx_tdata;
   logic        aurora_tx_tvalid;
   logic [63:0] aurora_rx_tdata;
   logic        aurora_rx_tvalid;
   logic        reg_wr;
   logic        reg_rd;
   logic [1:0]  reg_addr;
   logic [31:0] reg_wdata;
   logic [31:0] reg_rdata;

   logic [63:0] accepted_q[$];  // words taken by the link model, in order
   int          req_pending = 0;
   logic        tvalid_prev = 1'b0;

   always #5 AURORA_USER_CLK = ~AURORA_USER_CLK;

   ufc_bridge_top #(
      .FIFO_DATA_WIDTH   (32),
      .AURORA_DATA_WIDTH (64),
      .FIFO_DEPTH_LOG2   (4)
   ) DUT (
      .AURORA_USER_CLK  (AURORA_USER_CLK),
      .RESET            (RESET),
      .host_tx_data     (host_tx_data),
      .host_tx_wr       (host_tx_wr),
      .host_tx_full     (host_tx_full),
      .host_rx_data     (host_rx_data),
      .host_rx_rd       (host_rx_rd),
      .host_rx_empty    (host_rx_empty),
      .aurora_tx_req    (aurora_tx_req),
      .aurora_tx_ms     (aurora_tx_ms),
      .aurora_tx_tready (aurora_tx_tready),
      .aurora_tx_tdata  (aurora_tx_tdata),
      .aurora_tx_tvalid (aurora_tx_tvalid),
      .aurora_rx_tdata  (aurora_rx_tdata),
      .aurora_rx_tvalid (aurora_rx_tvalid),
      .reg_wr           (reg_wr),
      .reg_rd           (reg_rd),
      .reg_addr         (reg_addr),
      .reg_wdata        (reg_wdata),
      .reg_rdata        (reg_rdata)
   );

   task automatic stop_run(string line);
      $display("%s", line);
      $display("tests failed");
      $fatal(1, "simulation stopped at the first failure");
   endtask

   task automatic expect_equal(logic [63:0] actual, logic [63:0] expected, string what);
      assert (actual == expected) else
         stop_run($sformatf("error at %0t ns: %s is %h, expected %h",
                            $time, what, actual, expected));
   endtask

   task automatic settle(int cycles);
      repeat (cycles) @(negedge AURORA_USER_CLK);
   endtask

   task automatic wait_accepted(int count);
      int cycles;
      cycles = 0;
      while (accepted_q.size() < count) begin
         @(negedge AURORA_USER_CLK);
         cycles++;
         if (cycles > TIMEOUT_CYCLES)
            stop_run($sformatf("timeout: link saw %0d of %0d messages", accepted_q.size(), count));
      end
   endtask

   task automatic push_tx_word(logic [31:0] word);
      @(posedge AURORA_USER_CLK);
      host_tx_data <= word;
      host_tx_wr   <= 1'b1;
      @(posedge AURORA_USER_CLK);
      host_tx_wr   <= 1'b0;
   endtask

   task automatic pop_rx_word(output logic [31:0] word);
      int cycles;
      cycles = 0;
      @(negedge AURORA_USER_CLK);
      while (host_rx_empty) begin
         cycles++;
         if (cycles > TIMEOUT_CYCLES)
            stop_run("timeout: receive FIFO stayed empty while a word was expected");
         @(negedge AURORA_USER_CLK);
      end
      word = host_rx_data; // head word shows without a read
      @(posedge AURORA_USER_CLK);
      host_rx_rd <= 1'b1;
      @(posedge AURORA_USER_CLK);
      host_rx_rd <= 1'b0;
   endtask

   task automatic drive_link_word(logic [63:0] word);
      @(posedge AURORA_USER_CLK);
      aurora_rx_tdata  <= word;
      aurora_rx_tvalid <= 1'b1;
      @(posedge AURORA_USER_CLK);
      aurora_rx_tvalid <= 1'b0;
   endtask

   task automatic write_register(logic [1:0] addr, logic [31:0] data);
      @(posedge AURORA_USER_CLK);
      reg_addr  <= addr;
      reg_wdata <= data;
      reg_wr    <= 1'b1;
      @(posedge AURORA_USER_CLK);
      reg_wr    <= 1'b0;
   endtask

   // read data is valid in the cycle after reg_rd
   task automatic read_register(logic [1:0] addr, output logic [31:0] data);
      @(posedge AURORA_USER_CLK);
      reg_addr <= addr;
      reg_rd   <= 1'b1;
      @(posedge AURORA_USER_CLK);
      reg_rd   <= 1'b0;
      @(negedge AURORA_USER_CLK);
      data = reg_rdata;
   endtask

   task automatic check_reset_state();
      logic [31:0] data;
      @(negedge AURORA_USER_CLK);
      expect_equal(64'(aurora_tx_req), 64'd0, "req after reset");
      expect_equal(64'(aurora_tx_tvalid), 64'd0, "tvalid after reset");
      expect_equal(64'(host_rx_empty), 64'd1, "host_rx_empty after reset");
      expect_equal(64'(host_tx_full), 64'd0, "host_tx_full after reset");
      expect_equal(64'(reg_rdata), 64'd0, "reg_rdata after reset");
      read_register(bridge_reg_pkg::REG_STATUS, data);
      expect_equal(64'(data), 64'h6, "status after reset"); // both FIFOs empty, no err
      read_register(bridge_reg_pkg::REG_TX_MSG_COUNT, data);
      expect_equal(64'(data), 64'd0, "sent message count after reset");
      read_register(bridge_reg_pkg::REG_RX_WORD_COUNT, data);
      expect_equal(64'(data), 64'd0, "received word count after reset");
   endtask

   task automatic send_host_words();
      logic [31:0] words[$];
      logic [31:0] word;
      int          i;
      accepted_q.delete();
      for (i = 0; i < 10; i++) begin
         word = $urandom;
         words.push_back(word);
         push_tx_word(word);
      end
      wait_accepted(10);
      settle(12);
      expect_equal(64'(accepted_q.size()), 64'd10, "number of accepted messages");
      for (i = 0; i < 10; i++) begin
         expect_equal(accepted_q[i], {32'h0, words[i]}, $sformatf("tdata of message %0d", i));
      end
   endtask

   task automatic receive_link_words();
      logic [63:0] words[$];
      logic [31:0] word;
      int          i;
      for (i = 0; i < 8; i++) begin
         words.push_back({$urandom, $urandom});
         drive_link_word(words[i]);
      end
      for (i = 0; i < 8; i++) begin
         pop_rx_word(word);
         expect_equal(64'(word), 64'(words[i][31:0]), $sformatf("received word %0d", i));
      end
      @(negedge AURORA_USER_CLK);
      expect_equal(64'(host_rx_empty), 64'd1, "host_rx_empty after draining");
   endtask

   task automatic overflow_rx_fifo();
      logic [63:0] words[$];
      logic [31:0] word;
      logic [31:0] data;
      int          i;
      read_register(bridge_reg_pkg::REG_STATUS, data);
      expect_equal(64'(data[0]), 64'd0, "err before overflow");
      for (i = 0; i < 18; i++) begin
         words.push_back({$urandom, $urandom});
         drive_link_word(words[i]);
      end
      read_register(bridge_reg_pkg::REG_STATUS, data);
      expect_equal(64'(data[0]), 64'd1, "err after overflow");
      for (i = 0; i < 16; i++) begin
         pop_rx_word(word);
         expect_equal(64'(word), 64'(words[i][31:0]), $sformatf("word %0d after overflow", i));
      end
      read_register(bridge_reg_pkg::REG_STATUS, data);
      expect_equal(64'(data[0]), 64'd1, "err after drain"); // sticky until RESET
      expect_equal(64'(data[1]), 64'd1, "rx empty bit after drain");
   endtask

   task automatic check_counters();
      logic [31:0] data;
      int          i;
      // 10 messages so far, 8 + 18 link words including the two dropped
      read_register(bridge_reg_pkg::REG_TX_MSG_COUNT, data);
      expect_equal(64'(data), 64'd10, "sent message count");
      read_register(bridge_reg_pkg::REG_RX_WORD_COUNT, data);
      expect_equal(64'(data), 64'd26, "received word count");
      accepted_q.delete();
      for (i = 0; i < 2; i++) begin
         push_tx_word($urandom);
      end
      for (i = 0; i < 3; i++) begin
         drive_link_word({$urandom, $urandom});
      end
      wait_accepted(2);
      settle(4);
      read_register(bridge_reg_pkg::REG_TX_MSG_COUNT, data);
      expect_equal(64'(data), 64'd12, "sent message count after two more");
      read_register(bridge_reg_pkg::REG_RX_WORD_COUNT, data);
      expect_equal(64'(data), 64'd29, "received word count after three more");
      write_register(bridge_reg_pkg::REG_CONTROL, 32'h1);
      read_register(bridge_reg_pkg::REG_TX_MSG_COUNT, data);
      expect_equal(64'(data), 64'd0, "sent message count after clear");
      read_register(bridge_reg_pkg::REG_RX_WORD_COUNT, data);
      expect_equal(64'(data), 64'd0, "received word count after clear");
   endtask

   // link model answers tvalid with tready after 0 to 5 cycles
   initial begin : link_model
      logic [63:0] held;
      int          delay;
      int          i;
      aurora_tx_tready = 1'b0;
      forever begin
         @(negedge AURORA_USER_CLK);
         if (aurora_tx_tvalid === 1'b1) begin
            held  = aurora_tx_tdata;
            delay = int'($urandom % 6);
            for (i = 0; i < delay; i++) begin
               @(negedge AURORA_USER_CLK);
               assert (aurora_tx_tvalid === 1'b1) else
                  stop_run("tvalid dropped before the link gave tready");
               expect_equal(aurora_tx_tdata, held, "tdata while tready is withheld");
            end
            @(posedge AURORA_USER_CLK);
            aurora_tx_tready <= 1'b1;
            @(negedge AURORA_USER_CLK);
            assert (aurora_tx_tvalid === 1'b1) else
               stop_run("tvalid was low while the link gave tready");
            expect_equal(aurora_tx_tdata, held, "tdata while tready is given");
            @(posedge AURORA_USER_CLK); // bridge takes the word here
            aurora_tx_tready <= 1'b0;
            accepted_q.push_back(held);
         end
      end
   end

   // one req pulse per message, size code on every valid cycle
   always @(negedge AURORA_USER_CLK) begin
      if (RESET === 1'b0) begin
         if (aurora_tx_tvalid === 1'b1 && !tvalid_prev) begin
            expect_equal(64'(req_pending), 64'd1, "req pulses before tvalid");
            req_pending = 0;
         end
         if (aurora_tx_tvalid === 1'b1) begin
            expect_equal(64'(aurora_tx_ms), 64'd7, "message size code");
         end
         if (aurora_tx_req === 1'b1) begin
            req_pending++;
         end
         tvalid_prev = (aurora_tx_tvalid === 1'b1);
      end
   end

   initial begin
      void'($urandom(32'h4bc9a9de));
      RESET            = 1'b1;
      host_tx_data     = '0;
      host_tx_wr       = 1'b0;
      host_rx_rd       = 1'b0;
      aurora_rx_tdata  = '0;
      aurora_rx_tvalid = 1'b0;
      reg_wr           = 1'b0;
      reg_rd           = 1'b0;
      reg_addr         = '0;
      reg_wdata        = '0;
      repeat (4) @(posedge AURORA_USER_CLK);
      RESET <= 1'b0;
      check_reset_state();
      send_host_words();
      receive_link_words();
      overflow_rx_fifo();
      check_counters();
      $display("all tests passed");
      $finish;
   end

endmodule

`default_nettype wire

/* list.f */
hw/ufc_link_pkg.sv
hw/bridge_reg_pkg.sv
hw/ufc_bridge_if.sv
hw/sync_fifo.sv
hw/fifo_over_ufc.sv
hw/ufc_bridge_regs.sv
hw/ufc_bridge_top.sv
sim/tb_ufc_bridge.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
{ verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
     --top-module tb_ufc_bridge -f list.f -o tb_ufc_bridge &&
  ./obj_dir/tb_ufc_bridge; } > sim.log 2>&1 ||
  echo "build or simulation error, tests failed" >> sim.log
cat sim.log
grep -q "tests failed" sim.log && exit 1 || exit 0
